// File: flist.f
+incdir+.
cache_pkg.sv
cache_ctrl.sv
tag_array.sv
lru_ages.sv
data_array.sv
load_align.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f flist.f
	./$(OBJ_DIR)/V$(TOP) | awk '{print} /\*\* PASS \*\*/ {ok=1} END {exit !ok}'

clean:
	rm -rf $(OBJ_DIR)

// File: tb_cache.sv
`default_nettype none

`include "cache_defines.svh"

module tb_cache;

    localparam int NUM_ROWS    = 27;
    localparam int CYCLE_LIMIT = 128 + 10 + NUM_ROWS * 40;

    // Memory returns its word address scrambled with this pattern
    localparam logic [`CACHE_WORD_W-1:0] MEM_PATTERN = 32'ha5a5_0000;

    logic                       clk;
    logic                       rst;
    logic                       cpu_req;
    logic [`CACHE_ADDR_W-1:0]   cpu_addr;
    logic [`CACHE_WORD_W-1:0]   cpu_wdata;
    logic                       cpu_we;
    logic                       cpu_lb;
    logic                       cpu_lbu;
    wire                        cpu_ack;
    wire  [`CACHE_WORD_W-1:0]   cpu_rdata;
    wire                        mem_req;
    wire  [`CACHE_ADDR_W-1:0]   mem_addr;
    logic                       mem_ack;
    logic [`CACHE_WORD_W-1:0]   mem_rdata;

    // Stimulus table, one request per row
    logic [95:0]                row_name  [NUM_ROWS];
    logic [`CACHE_ADDR_W-1:0]   row_addr  [NUM_ROWS];
    logic                       row_we    [NUM_ROWS];
    logic                       row_lb    [NUM_ROWS];
    logic                       row_lbu   [NUM_ROWS];
    logic [`CACHE_WORD_W-1:0]   row_wdata [NUM_ROWS];
    logic [`CACHE_WORD_W-1:0]   row_rdata [NUM_ROWS];
    logic [7:0]                 row_txn   [NUM_ROWS];
    int                         row_count;

    logic [95:0]                cur_name;
    logic [`CACHE_WORD_W-1:0]   exp_rdata;
    logic [7:0]                 exp_txn;
    logic [31:0]                checks_done;
    logic [31:0]                value_errors;
    logic [31:0]                protocol_errors;

    logic [31:0]                lfsr_state;
    logic [1:0]                 mem_delay;
    logic                       mem_busy;
    int                         cycle_count;

    cache_top UUT (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_we     (cpu_we),
        .cpu_lb     (cpu_lb),
        .cpu_lbu    (cpu_lbu),
        .cpu_ack    (cpu_ack),
        .cpu_rdata  (cpu_rdata),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    cache_checker u_check (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .cpu_we          (cpu_we),
        .cpu_ack         (cpu_ack),
        .cpu_rdata       (cpu_rdata),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .mem_ack         (mem_ack),
        .test_name       (cur_name),
        .exp_rdata       (exp_rdata),
        .exp_txn         (exp_txn),
        .checks_done     (checks_done),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR, the bit taken is the one shifted out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory model with a random 0 to 3 cycle answer delay
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        mem_busy   = 1'b0;
        mem_delay  = 2'd0;
        lfsr_state = 32'h5fe4_9541;
        forever
        begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (mem_req)
            begin
                // New word request, draw its delay
                if (!mem_busy)
                begin
                    mem_busy = 1'b1;
                    for (int b = 0; b < 2; b++)
                    begin
                        mem_delay  = {mem_delay[0], lfsr_state[0]};
                        lfsr_state = lfsr_step(lfsr_state);
                    end
                end
                if (mem_delay == 2'd0)
                begin
                    mem_ack   = 1'b1;
                    mem_rdata = mem_addr ^ MEM_PATTERN;
                    mem_busy  = 1'b0;
                end
                else
                    mem_delay = mem_delay - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic add_row(input logic [95:0] name, input logic [31:0] addr,
                           input logic we, input logic lb, input logic lbu,
                           input logic [31:0] wdata, input logic [31:0] rdata,
                           input logic [7:0] txn);
        row_name[row_count]  = name;
        row_addr[row_count]  = addr;
        row_we[row_count]    = we;
        row_lb[row_count]    = lb;
        row_lbu[row_count]   = lbu;
        row_wdata[row_count] = wdata;
        row_rdata[row_count] = rdata;
        row_txn[row_count]   = txn;
        row_count            = row_count + 1;
    endtask

    task automatic fill_table();
        row_count = 0;
        // Cold miss, then a hit on the same line
        add_row("ld_miss", 32'h0000_0104, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0104 ^ MEM_PATTERN, 8'd4);
        add_row("ld_hit", 32'h0000_0104, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0104 ^ MEM_PATTERN, 8'd0);
        // Store hit, read back, then every byte lane
        add_row("st_hit", 32'h0000_0108, 1'b1, 1'b0, 1'b0, 32'h8091_a2f3, '0, 8'd0);
        add_row("ld_stored", 32'h0000_0108, 1'b0, 1'b0, 1'b0, '0, 32'h8091_a2f3, 8'd0);
        add_row("lb_0", 32'h0000_0108, 1'b0, 1'b1, 1'b0, '0, 32'hffff_fff3, 8'd0);
        add_row("lbu_0", 32'h0000_0108, 1'b0, 1'b0, 1'b1, '0, 32'h0000_00f3, 8'd0);
        add_row("lb_1", 32'h0000_0109, 1'b0, 1'b1, 1'b0, '0, 32'hffff_ffa2, 8'd0);
        add_row("lbu_1", 32'h0000_0109, 1'b0, 1'b0, 1'b1, '0, 32'h0000_00a2, 8'd0);
        add_row("lb_2", 32'h0000_010a, 1'b0, 1'b1, 1'b0, '0, 32'hffff_ff91, 8'd0);
        add_row("lbu_2", 32'h0000_010a, 1'b0, 1'b0, 1'b1, '0, 32'h0000_0091, 8'd0);
        add_row("lb_3", 32'h0000_010b, 1'b0, 1'b1, 1'b0, '0, 32'hffff_ff80, 8'd0);
        add_row("lbu_3", 32'h0000_010b, 1'b0, 1'b0, 1'b1, '0, 32'h0000_0080, 8'd0);
        // Set 0x20: A B C D fill the ways, A again, E evicts B
        add_row("fill_a", 32'h0000_0200, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0200 ^ MEM_PATTERN, 8'd4);
        add_row("fill_b", 32'h0000_0a00, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0a00 ^ MEM_PATTERN, 8'd4);
        add_row("fill_c", 32'h0000_1200, 1'b0, 1'b0, 1'b0, '0, 32'h0000_1200 ^ MEM_PATTERN, 8'd4);
        add_row("fill_d", 32'h0000_1a00, 1'b0, 1'b0, 1'b0, '0, 32'h0000_1a00 ^ MEM_PATTERN, 8'd4);
        add_row("touch_a", 32'h0000_0200, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0200 ^ MEM_PATTERN, 8'd0);
        add_row("fill_e", 32'h0000_2200, 1'b0, 1'b0, 1'b0, '0, 32'h0000_2200 ^ MEM_PATTERN, 8'd4);
        add_row("keep_a", 32'h0000_0200, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0200 ^ MEM_PATTERN, 8'd0);
        add_row("lost_b", 32'h0000_0a00, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0a00 ^ MEM_PATTERN, 8'd4);
        // Set 0x30: store allocates F, four more tags push it out
        add_row("st_alloc_f", 32'h0000_0304, 1'b1, 1'b0, 1'b0, 32'h1234_5678, '0, 8'd4);
        add_row("ld_f", 32'h0000_0304, 1'b0, 1'b0, 1'b0, '0, 32'h1234_5678, 8'd0);
        add_row("fill_g", 32'h0000_0b04, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0b04 ^ MEM_PATTERN, 8'd4);
        add_row("fill_h", 32'h0000_1304, 1'b0, 1'b0, 1'b0, '0, 32'h0000_1304 ^ MEM_PATTERN, 8'd4);
        add_row("fill_i", 32'h0000_1b04, 1'b0, 1'b0, 1'b0, '0, 32'h0000_1b04 ^ MEM_PATTERN, 8'd4);
        add_row("fill_j", 32'h0000_2304, 1'b0, 1'b0, 1'b0, '0, 32'h0000_2304 ^ MEM_PATTERN, 8'd4);
        add_row("reload_f", 32'h0000_0304, 1'b0, 1'b0, 1'b0, '0, 32'h0000_0304 ^ MEM_PATTERN, 8'd4);
    endtask

    // One request, held until the cache acknowledges it
    task automatic apply_row(input int r);
        @(posedge clk);
        #1;
        cur_name  = row_name[r];
        exp_rdata = row_rdata[r];
        exp_txn   = row_txn[r];
        cpu_addr  = row_addr[r];
        cpu_we    = row_we[r];
        cpu_lb    = row_lb[r];
        cpu_lbu   = row_lbu[r];
        cpu_wdata = row_wdata[r];
        cpu_req   = 1'b1;
        while (!cpu_ack)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cpu_req = 1'b0;
    endtask

    task automatic finish_run(input int timeouts);
        $display("Checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 checks_done, value_errors, protocol_errors, timeouts);
        if (timeouts == 0 && value_errors == 0 && protocol_errors == 0 && checks_done != 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    initial
    begin
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_we    = 1'b0;
        cpu_lb    = 1'b0;
        cpu_lbu   = 1'b0;
        cur_name  = '0;
        exp_rdata = '0;
        exp_txn   = '0;
        fill_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        // Requests raised during the sweep simply wait for it
        for (int r = 0; r < row_count; r++)
            apply_row(r);
        repeat (2) @(posedge clk);
        finish_run(0);
    end

    // Run limit from sweep, reset and a budget per row
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        finish_run(1);
    end

endmodule

`default_nettype wire

// File: cache_checker.sv
`default_nettype none

`include "cache_defines.svh"

module cache_checker import cache_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         cpu_req,
    input  wire                         cpu_we,
    input  wire                         cpu_ack,
    input  wire [`CACHE_WORD_W-1:0]     cpu_rdata,
    input  wire                         mem_req,
    input  wire cache_addr_u            mem_addr,
    input  wire                         mem_ack,
    input  wire [95:0]                  test_name,
    input  wire [`CACHE_WORD_W-1:0]     exp_rdata,
    input  wire [7:0]                   exp_txn,
    output logic [31:0]                 checks_done,
    output logic [31:0]                 value_errors,
    output logic [31:0]                 protocol_errors
);

    logic [7:0] txn_seen;
    logic       mem_waiting;

    always @(posedge clk)
    begin
        if (rst)
        begin
            txn_seen        = '0;
            mem_waiting     = 1'b0;
            checks_done     = '0;
            value_errors    = '0;
            protocol_errors = '0;
        end
        else
        begin
            //////////////////////////////////////////////////////////////////////
            // Memory handshake
            //////////////////////////////////////////////////////////////////////

            if (mem_waiting && !mem_req)
            begin
                $display("Memory request withdrawn before it was acknowledged");
                protocol_errors = protocol_errors + 32'd1;
            end
            if (mem_req && mem_addr.f.byte_off != '0)
            begin
                $display("Memory request address %h is not word aligned", mem_addr.raw);
                protocol_errors = protocol_errors + 32'd1;
            end
            if (mem_req && mem_ack)
                txn_seen = txn_seen + 8'd1;
            mem_waiting = mem_req && !mem_ack;

            //////////////////////////////////////////////////////////////////////
            // CPU response
            //////////////////////////////////////////////////////////////////////

            if (cpu_ack && !cpu_req)
            begin
                $display("CPU acknowledge seen without a CPU request");
                protocol_errors = protocol_errors + 32'd1;
            end
            else if (cpu_ack)
            begin
                checks_done = checks_done + 32'd1;
                if (txn_seen != exp_txn)
                begin
                    $display("Fail %0s: memory transactions expected %0d, actual %0d",
                             test_name, exp_txn, txn_seen);
                    value_errors = value_errors + 32'd1;
                end
                // Store acknowledges carry no data
                if (!cpu_we)
                begin
                    checks_done = checks_done + 32'd1;
                    if (cpu_rdata !== exp_rdata)
                    begin
                        $display("Fail %0s: load data expected %h, actual %h",
                                 test_name, exp_rdata, cpu_rdata);
                        value_errors = value_errors + 32'd1;
                    end
                end
                txn_seen = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_top.sv
`default_nettype none

`include "cache_defines.svh"

module cache_top import cache_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    // CPU side
    input  wire                         cpu_req,
    input  wire [`CACHE_ADDR_W-1:0]     cpu_addr,
    input  wire [`CACHE_WORD_W-1:0]     cpu_wdata,
    input  wire                         cpu_we,
    input  wire                         cpu_lb,
    input  wire                         cpu_lbu,
    output logic                        cpu_ack,
    output logic [`CACHE_WORD_W-1:0]    cpu_rdata,
    // Memory side
    output logic                        mem_req,
    output logic [`CACHE_ADDR_W-1:0]    mem_addr,
    input  wire                         mem_ack,
    input  wire [`CACHE_WORD_W-1:0]     mem_rdata
);

    logic                                   hit;
    logic [`CACHE_WAY_W-1:0]                hit_way;
    logic [`CACHE_WAYS-1:0]                 valid_ways;
    logic [`CACHE_WAY_W-1:0]                access_way;
    logic                                   sweep_en;
    logic [`CACHE_INDEX_W-1:0]              sweep_set;
    logic                                   fill_we;
    logic [$clog2(`CACHE_LINE_WORDS)-1:0]   fill_word;
    logic                                   store_we;
    logic                                   tag_we;
    logic                                   age_update;
    word_bytes_u                            rd_word;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .hit        (hit),
        .mem_ack    (mem_ack),
        .cpu_ack    (cpu_ack),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .sweep_en   (sweep_en),
        .sweep_set  (sweep_set),
        .fill_we    (fill_we),
        .fill_word  (fill_word),
        .store_we   (store_we),
        .tag_we     (tag_we),
        .age_update (age_update)
    );

    tag_array u_tags (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .sweep_en   (sweep_en),
        .sweep_set  (sweep_set),
        .tag_we     (tag_we),
        .access_way (access_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .valid_ways (valid_ways)
    );

    lru_ages u_ages (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .sweep_en   (sweep_en),
        .sweep_set  (sweep_set),
        .age_update (age_update),
        .hit        (hit),
        .hit_way    (hit_way),
        .valid_ways (valid_ways),
        .access_way (access_way)
    );

    data_array u_data (
        .clk        (clk),
        .cpu_addr   (cpu_addr),
        .access_way (access_way),
        .fill_we    (fill_we),
        .fill_word  (fill_word),
        .store_we   (store_we),
        .cpu_wdata  (cpu_wdata),
        .mem_rdata  (mem_rdata),
        .rd_word    (rd_word)
    );

    load_align u_align (
        .rd_word    (rd_word),
        .cpu_addr   (cpu_addr),
        .cpu_lb     (cpu_lb),
        .cpu_lbu    (cpu_lbu),
        .cpu_rdata  (cpu_rdata)
    );

endmodule

`default_nettype wire

// File: load_align.sv
`default_nettype none

`include "cache_defines.svh"

module load_align import cache_pkg::*;
(
    input  wire word_bytes_u                rd_word,
    input  wire cache_addr_u                cpu_addr,
    input  wire                             cpu_lb,
    input  wire                             cpu_lbu,
    output logic [`CACHE_WORD_W-1:0]        cpu_rdata
);

    logic [7:0] lane;

    assign lane = rd_word.bytes[cpu_addr.f.byte_off];

    always_comb
    begin
        if (cpu_lb)
            cpu_rdata = {{(`CACHE_WORD_W-8){lane[7]}}, lane};
        else if (cpu_lbu)
            cpu_rdata = {{(`CACHE_WORD_W-8){1'b0}}, lane};
        else
            // Plain word load
            cpu_rdata = rd_word.raw;
    end

endmodule

`default_nettype wire

// File: data_array.sv
`default_nettype none

`include "cache_defines.svh"

module data_array import cache_pkg::*;
(
    input  wire                                     clk,
    input  wire cache_addr_u                        cpu_addr,
    input  wire [`CACHE_WAY_W-1:0]                  access_way,
    input  wire                                     fill_we,
    input  wire [$clog2(`CACHE_LINE_WORDS)-1:0]     fill_word,
    input  wire                                     store_we,
    input  wire [`CACHE_WORD_W-1:0]                 cpu_wdata,
    input  wire [`CACHE_WORD_W-1:0]                 mem_rdata,
    output word_bytes_u                             rd_word
);

    logic [`CACHE_WORD_W-1:0] line_mem [`CACHE_SETS][`CACHE_WAYS][`CACHE_LINE_WORDS];

    // All ways of the set, the way is only known after the tag read
    logic [`CACHE_WORD_W-1:0] line_q [`CACHE_WAYS][`CACHE_LINE_WORDS];

    always_ff @(posedge clk)
    begin
        if (fill_we)
            line_mem[cpu_addr.f.index][access_way][fill_word] <= mem_rdata;
        else if (store_we)
            line_mem[cpu_addr.f.index][access_way][cpu_addr.f.word_off] <= cpu_wdata;

        for (int w = 0; w < `CACHE_WAYS; w++)
            for (int k = 0; k < `CACHE_LINE_WORDS; k++)
                line_q[w][k] <= line_mem[cpu_addr.f.index][w][k];
    end

    // Narrow to the requested word of the selected way
    assign rd_word = line_q[access_way][cpu_addr.f.word_off];

endmodule

`default_nettype wire

// File: lru_ages.sv
`default_nettype none

`include "cache_defines.svh"

module lru_ages import cache_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire cache_addr_u            cpu_addr,
    input  wire                         sweep_en,
    input  wire [`CACHE_INDEX_W-1:0]    sweep_set,
    input  wire                         age_update,
    input  wire                         hit,
    input  wire [`CACHE_WAY_W-1:0]      hit_way,
    input  wire [`CACHE_WAYS-1:0]       valid_ways,
    output logic [`CACHE_WAY_W-1:0]     access_way
);

    logic [`CACHE_AGE_W-1:0]    age_mem [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_AGE_W-1:0]    age_q [`CACHE_WAYS];
    logic [`CACHE_AGE_W-1:0]    age_nxt [`CACHE_WAYS];
    logic [`CACHE_AGE_W-1:0]    oldest;
    logic [`CACHE_WAY_W-1:0]    victim;

    always_ff @(posedge clk)
    begin
        if (sweep_en)
        begin
            for (int w = 0; w < `CACHE_WAYS; w++)
                age_mem[sweep_set][w] <= '0;
        end
        else if (age_update)
        begin
            for (int w = 0; w < `CACHE_WAYS; w++)
                age_mem[cpu_addr.f.index][w] <= age_nxt[w];
        end
    end

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < `CACHE_WAYS; w++)
            age_q[w] <= rst ? '0 : age_mem[cpu_addr.f.index][w];
    end

    // Accessed way gets young, the others age up to the ceiling
    always_comb
    begin
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (`CACHE_WAY_W'(w) == access_way)
                age_nxt[w] = '0;
            else if (age_q[w] == '1)
                age_nxt[w] = age_q[w];
            else
                age_nxt[w] = age_q[w] + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Victim choice
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        victim = '0;
        oldest = '0;
        // Strict compare keeps the lowest way on a tie
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (age_q[w] > oldest)
            begin
                oldest = age_q[w];
                victim = `CACHE_WAY_W'(w);
            end
        end
        // A free way beats any age
        for (int w = `CACHE_WAYS-1; w >= 0; w--)
            if (!valid_ways[w])
                victim = `CACHE_WAY_W'(w);
    end

    assign access_way = hit ? hit_way : victim;

endmodule

`default_nettype wire

// File: tag_array.sv
`default_nettype none

`include "cache_defines.svh"

module tag_array import cache_pkg::*;
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire cache_addr_u                cpu_addr,
    input  wire                             sweep_en,
    input  wire [`CACHE_INDEX_W-1:0]        sweep_set,
    input  wire                             tag_we,
    input  wire [`CACHE_WAY_W-1:0]          access_way,
    output logic                            hit,
    output logic [`CACHE_WAY_W-1:0]         hit_way,
    output logic [`CACHE_WAYS-1:0]          valid_ways
);

    logic [`CACHE_TAG_W-1:0]    tag_mem [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]     valid_mem [`CACHE_SETS];

    logic [`CACHE_TAG_W-1:0]    tag_q [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]     valid_q;
    logic [`CACHE_WAYS-1:0]     match;

    // Tag store and registered read of the addressed set
    always_ff @(posedge clk)
    begin
        if (tag_we)
            tag_mem[cpu_addr.f.index][access_way] <= cpu_addr.f.tag;
        for (int w = 0; w < `CACHE_WAYS; w++)
            tag_q[w] <= tag_mem[cpu_addr.f.index][w];
    end

    // Sweep wipes a whole set, refill validates one way
    always_ff @(posedge clk)
    begin
        if (sweep_en)
            valid_mem[sweep_set] <= '0;
        else if (tag_we)
            valid_mem[cpu_addr.f.index][access_way] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_q <= '0;
        else
            valid_q <= valid_mem[cpu_addr.f.index];
    end

    //////////////////////////////////////////////////////////////////////
    // Compare and hit way
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int w = 0; w < `CACHE_WAYS; w++)
            match[w] = valid_q[w] && (tag_q[w] == cpu_addr.f.tag);
    end

    // Lowest matching way wins
    always_comb
    begin
        hit_way = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--)
            if (match[w])
                hit_way = `CACHE_WAY_W'(w);
    end

    assign hit        = |match;
    assign valid_ways = valid_q;

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`default_nettype none

`include "cache_defines.svh"

module cache_ctrl import cache_pkg::*;
(
    input  wire                                     clk,
    input  wire                                     rst,
    input  wire                                     cpu_req,
    input  wire                                     cpu_we,
    input  wire cache_addr_u                        cpu_addr,
    input  wire                                     hit,
    input  wire                                     mem_ack,
    output logic                                    cpu_ack,
    output logic                                    mem_req,
    output logic [`CACHE_ADDR_W-1:0]                mem_addr,
    output logic                                    sweep_en,
    output logic [`CACHE_INDEX_W-1:0]               sweep_set,
    output logic                                    fill_we,
    output logic [$clog2(`CACHE_LINE_WORDS)-1:0]    fill_word,
    output logic                                    store_we,
    output logic                                    tag_we,
    output logic                                    age_update
);

    localparam int BYTE_OFF_W = $clog2(`CACHE_WORD_W/8);

    localparam logic [2:0] ST_SWEEP   = 3'd0;
    localparam logic [2:0] ST_IDLE    = 3'd1;
    localparam logic [2:0] ST_LOOKUP  = 3'd2;
    localparam logic [2:0] ST_RESPOND = 3'd3;
    localparam logic [2:0] ST_REFILL  = 3'd4;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       last_word;

    //////////////////////////////////////////////////////////////////////
    // State, sweep counter and fill counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ST_SWEEP;
            sweep_set <= '0;
            fill_word <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (sweep_en)
                sweep_set <= sweep_set + `CACHE_INDEX_W'(1);
            // Wraps back to word 0 after the last one of the line
            if (fill_we)
                fill_word <= fill_word + 1'b1;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_SWEEP:
                if (sweep_set == `CACHE_INDEX_W'(`CACHE_SETS-1))
                    state_nxt = ST_IDLE;
            ST_IDLE:
                if (cpu_req)
                    state_nxt = ST_LOOKUP;
            ST_LOOKUP:
                state_nxt = hit ? ST_RESPOND : ST_REFILL;
            ST_RESPOND:
                state_nxt = ST_IDLE;
            ST_REFILL:
                // Line complete, look up again so the hit path answers
                if (tag_we)
                    state_nxt = ST_IDLE;
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Strobes toward the datapath
    //////////////////////////////////////////////////////////////////////

    assign sweep_en   = (state == ST_SWEEP);
    assign cpu_ack    = (state == ST_RESPOND);
    assign age_update = (state == ST_RESPOND);
    assign store_we   = (state == ST_RESPOND) && cpu_we;

    assign last_word  = (fill_word == $clog2(`CACHE_LINE_WORDS)'(`CACHE_LINE_WORDS-1));
    assign fill_we    = (state == ST_REFILL) && mem_ack;
    assign tag_we     = fill_we && last_word;

    // Refill walks the line from word 0 upward
    assign mem_req    = (state == ST_REFILL);
    assign mem_addr   = {cpu_addr.f.tag, cpu_addr.f.index, fill_word, {BYTE_OFF_W{1'b0}}};

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    // Request address, raw or split into its cache fields
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        struct packed {
            logic [`CACHE_TAG_W-1:0]                tag;
            logic [`CACHE_INDEX_W-1:0]              index;
            logic [$clog2(`CACHE_LINE_WORDS)-1:0]   word_off;
            logic [$clog2(`CACHE_WORD_W/8)-1:0]     byte_off;
        } f;
    } cache_addr_u;

    // Data word, whole or as byte lanes (lane 0 is the low byte)
    typedef union packed {
        logic [`CACHE_WORD_W-1:0]       raw;
        logic [`CACHE_WORD_W/8-1:0][7:0] bytes;
    } word_bytes_u;

endpackage

`default_nettype wire

// File: cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Word and address widths
//////////////////////////////////////////////////////////////////////

`define CACHE_WORD_W        32
`define CACHE_ADDR_W        32

// Address fields, tag on top of index on top of the line offset
`define CACHE_TAG_W         21
`define CACHE_INDEX_W       7

//////////////////////////////////////////////////////////////////////
// Geometry
//////////////////////////////////////////////////////////////////////

`define CACHE_SETS          128
`define CACHE_WAYS          4
`define CACHE_WAY_W         2
`define CACHE_LINE_WORDS    4

// Saturating replacement age per way
`define CACHE_AGE_W         2

`endif
